//--- ring_config.svh
/*
 * Build-time sizes for the host ring receive path.
 * Line width, ring index width, reorder scoreboard depth
 * and the host cache-line address width.
 */

`ifndef RING_CONFIG_SVH
`define RING_CONFIG_SVH

// ====================
// Payload
// ====================

// One ring line as carried through simulation
`define RING_DATA_W 32

// ====================
// Ring and scoreboard
// ====================

// Ring index width, so the ring holds 2**RING_IDX_W lines
// The ring size must stay a power of two because the pointers wrap
`define RING_IDX_W 4

// Number of reads that may be outstanding at once, a power of two
`define SB_ENTRIES 8

// Host cache-line address width
`define LINE_ADDR_W 26

`endif

//--- host_chan_pkg.sv
/*
 * Host channel types: line address, read tag, line payload,
 * and the packed read request and read response.
 */

`default_nettype none

`include "ring_config.svh"

package host_chan_pkg;

    // Cache-line address in host memory
    typedef logic [`LINE_ADDR_W-1:0] line_addr_t;

    // Read tag, sized to name one scoreboard entry
    typedef logic [$clog2(`SB_ENTRIES)-1:0] chan_tag_t;

    // One line of payload
    typedef logic [`RING_DATA_W-1:0] line_data_t;

    // ====================
    // Read request
    // ====================

    // The request bit is held until a grant arrives in the same cycle
    // The tag comes back unchanged on the matching response
    typedef struct packed {
        logic       request;
        line_addr_t address;
        chan_tag_t  tag;
    } host_read_req_t;

    // ====================
    // Read response
    // ====================

    // Single-cycle strobe, responses arrive in any order
    // is_ring marks a response that belongs to the ring reader, others
    // are for different clients sharing the channel
    typedef struct packed {
        logic       valid;
        logic       is_ring;
        chan_tag_t  tag;
        line_data_t data;
    } host_read_rsp_t;

endpackage

`default_nettype wire

//--- ring_pkg.sv
/*
 * Ring-side types: wrapping ring index, scoreboard entry index
 * and the oldest/newest pointer pair.
 */

`default_nettype none

`include "ring_config.svh"

package ring_pkg;

    // Index into the host ring
    // Wraps from the last line to the first by plain overflow
    typedef logic [`RING_IDX_W-1:0] ring_idx_t;

    // Index of one reorder scoreboard entry
    typedef logic [$clog2(`SB_ENTRIES)-1:0] sb_idx_t;

    // ====================
    // Pointer state
    // ====================

    // oldest_idx is the first line not yet handed to the consumer queue
    // newest_idx is the first line the host has not yet written
    // The ring is empty from the reader's side when the two match
    typedef struct packed {
        ring_idx_t oldest_idx;
        ring_idx_t newest_idx;
    } ring_status_t;

endpackage

`default_nettype wire

//--- stage_fifo2.sv
/*
 * Two-entry registered FIFO between the reorder scoreboard
 * and the consumer. The head is always a register.
 */

`default_nettype none

module stage_fifo2
(
    input  logic                    clk,
    input  logic                    reset_n,

    input  host_chan_pkg::line_data_t enq_data,
    input  logic                    enq_en,
    output logic                    not_full,

    output host_chan_pkg::line_data_t first,
    input  logic                    deq_en,
    output logic                    not_empty
);

    import host_chan_pkg::*;

    // Entry 0 always holds the older line, entry 1 the younger
    line_data_t data_q [2];

    // Number of valid entries, 0 to 2
    logic [1:0] count;

    assign first     = data_q[0];
    assign not_empty = (count != 2'd0);
    assign not_full  = (count != 2'd2);

    // Lines shift toward entry 0 as the head leaves
    always_ff @(posedge clk)
    begin
        case ({enq_en, deq_en})
            2'b10:
            begin
                // Land in the first free slot
                if (count == 2'd0)
                    data_q[0] <= enq_data;
                else
                    data_q[1] <= enq_data;
            end
            2'b01:
            begin
                // Shift the younger line to the head
                data_q[0] <= data_q[1];
            end
            2'b11:
            begin
                // Head leaves while a new line arrives
                if (count == 2'd2)
                begin
                    data_q[0] <= data_q[1];
                    data_q[1] <= enq_data;
                end
                else
                begin
                    data_q[0] <= enq_data;
                end
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            count <= 2'd0;
        else if (enq_en && !deq_en)
            count <= count + 2'd1;
        else if (deq_en && !enq_en)
            count <= count - 2'd1;
    end

endmodule

`default_nettype wire

//--- reorder_scoreboard.sv
/*
 * Reorder scoreboard for out-of-order read responses.
 * Slots are allocated in order at the tail, filled in any order,
 * and released from the head only once the head is filled.
 */

`default_nettype none

`include "ring_config.svh"

module reorder_scoreboard
(
    input  logic                      clk,
    input  logic                      reset_n,

    // Allocation of a slot for a newly granted read
    input  logic                      alloc_en,
    output logic                      not_full,
    output ring_pkg::sb_idx_t         alloc_idx,

    // Response data landing in the slot named by its tag
    input  logic                      fill_en,
    input  ring_pkg::sb_idx_t         fill_idx,
    input  host_chan_pkg::line_data_t fill_data,

    // In-order release of the oldest slot
    input  logic                      deq_en,
    output logic                      not_empty,
    output host_chan_pkg::line_data_t first
);

    import host_chan_pkg::*;
    import ring_pkg::*;

    localparam int unsigned DEPTH = `SB_ENTRIES;

    // The outstanding count must reach DEPTH itself, so one extra bit
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // ====================
    // Storage
    // ====================

    // Line storage, written by responses and read at the head
    line_data_t mem [DEPTH];

    // Set when a response has written the entry, cleared on release
    logic [DEPTH-1:0] filled;

    // Oldest allocated entry and next entry to hand out
    sb_idx_t head;
    sb_idx_t tail;

    // Entries allocated and not yet released
    logic [CNT_W-1:0] outstanding;

    // ====================
    // Status outputs
    // ====================

    // Full once every entry is waiting on a response or on release
    assign not_full  = (outstanding != CNT_W'(DEPTH));
    assign alloc_idx = tail;

    // The head can leave only after its own response arrived
    // Later entries may already be filled, they simply wait their turn
    assign not_empty = filled[head];
    assign first     = mem[head];

    // Responses may target any outstanding entry
    always_ff @(posedge clk)
    begin
        if (fill_en)
            mem[fill_idx] <= fill_data;
    end

    // ====================
    // Control state
    // ====================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            filled <= '0;
        end
        else
        begin
            // The released head and the filled entry are never the same
            // slot, since only a filled head can be released
            if (deq_en)
                filled[head] <= 1'b0;
            if (fill_en)
                filled[fill_idx] <= 1'b1;
        end
    end

    // Head and tail wrap by overflow because DEPTH is a power of two
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            head <= '0;
            tail <= '0;
        end
        else
        begin
            if (alloc_en)
                tail <= tail + sb_idx_t'(1);
            if (deq_en)
                head <= head + sb_idx_t'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            outstanding <= '0;
        else if (alloc_en && !deq_en)
            outstanding <= outstanding + CNT_W'(1);
        else if (deq_en && !alloc_en)
            outstanding <= outstanding - CNT_W'(1);
    end

endmodule

`default_nettype wire

//--- ring_fifo_reader.sv
/*
 * Ring reader: issues one line read per granted request,
 * sorts responses through the reorder scoreboard, stages lines
 * for the consumer and reports the oldest unconsumed ring index.
 */

`default_nettype none

module ring_fifo_reader
(
    input  logic                          clk,
    input  logic                          reset_n,

    // Ring placement and pointers shared with the status path
    input  host_chan_pkg::line_addr_t     ring_base,
    input  ring_pkg::ring_idx_t           newest_idx,
    output ring_pkg::ring_idx_t           oldest_idx,

    // Host read channel
    output host_chan_pkg::host_read_req_t read_req,
    input  logic                          read_grant,
    input  host_chan_pkg::host_read_rsp_t read_rsp,

    // Consumer side
    output host_chan_pkg::line_data_t     rx_data,
    output logic                          rx_rdy,
    input  logic                          rx_enable
);

    import host_chan_pkg::*;
    import ring_pkg::*;

    // Next ring line to request from the host
    ring_idx_t next_req_idx;

    // First ring line not yet moved to the consumer queue
    ring_idx_t oldest_q;

    // Scoreboard handshake
    sb_idx_t    sb_slot_idx;
    logic       sb_not_full;
    logic       sb_not_empty;
    line_data_t sb_first;

    // Consumer queue handshake and the move between the two
    logic fifo_not_full;
    logic xfer_en;

    // Responses for this reader, with everything else on the channel ignored
    logic rsp_accept;

    assign rsp_accept = read_rsp.valid && read_rsp.is_ring;

    // A ready head moves on whenever the consumer queue has space
    assign xfer_en = sb_not_empty && fifo_not_full;

    // ====================
    // Read requests
    // ====================

    always_comb
    begin
        // Data waits in the ring and a scoreboard slot is free to take it
        read_req.request = (next_req_idx != newest_idx) && sb_not_full;

        // Add rather than replace low bits, so the base need not be aligned
        // to the ring size
        read_req.address = ring_base + line_addr_t'(next_req_idx);

        // The tag names the scoreboard slot the response must land in
        read_req.tag = chan_tag_t'(sb_slot_idx);
    end

    // A grant accepts this cycle's request, so step to the next line
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            next_req_idx <= '0;
        else if (read_grant)
            next_req_idx <= next_req_idx + ring_idx_t'(1);
    end

    // ====================
    // Release pointer
    // ====================

    // Advanced as lines leave the scoreboard in ring order
    // The host may reuse a slot only once its line is past this point
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            oldest_q <= '0;
        else if (xfer_en)
            oldest_q <= oldest_q + ring_idx_t'(1);
    end

    assign oldest_idx = oldest_q;

    reorder_scoreboard u_scoreboard
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .alloc_en  (read_grant),
        .not_full  (sb_not_full),
        .alloc_idx (sb_slot_idx),
        .fill_en   (rsp_accept),
        .fill_idx  (sb_idx_t'(read_rsp.tag)),
        .fill_data (read_rsp.data),
        .deq_en    (xfer_en),
        .not_empty (sb_not_empty),
        .first     (sb_first)
    );

    // Registered staging keeps the consumer off the scoreboard read path
    stage_fifo2 u_out_fifo
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_data  (sb_first),
        .enq_en    (xfer_en),
        .not_full  (fifo_not_full),
        .first     (rx_data),
        .deq_en    (rx_enable),
        .not_empty (rx_rdy)
    );

endmodule

`default_nettype wire

//--- host_ring_rx.sv
/*
 * Top level of the ring receive path.
 * Attaches the single ring reader to the host channel.
 */

`default_nettype none

module host_ring_rx
(
    input  logic                          clk,
    input  logic                          reset_n,

    input  host_chan_pkg::line_addr_t     ring_base,
    input  ring_pkg::ring_idx_t           newest_idx,
    output ring_pkg::ring_idx_t           oldest_idx,

    output host_chan_pkg::host_read_req_t read_req,
    input  logic                          read_grant,
    input  host_chan_pkg::host_read_rsp_t read_rsp,

    output host_chan_pkg::line_data_t     rx_data,
    output logic                          rx_rdy,
    input  logic                          rx_enable
);

    import host_chan_pkg::*;
    import ring_pkg::*;

    // Reader side of the host channel
    // A channel arbiter for further clients would sit between these and the ports
    host_read_req_t reader_req;
    host_read_rsp_t reader_rsp;
    ring_idx_t      reader_oldest;

    assign read_req   = reader_req;
    assign reader_rsp = read_rsp;
    assign oldest_idx = reader_oldest;

    ring_fifo_reader u_reader
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .ring_base  (ring_base),
        .newest_idx (newest_idx),
        .oldest_idx (reader_oldest),
        .read_req   (reader_req),
        .read_grant (read_grant),
        .read_rsp   (reader_rsp),
        .rx_data    (rx_data),
        .rx_rdy     (rx_rdy),
        .rx_enable  (rx_enable)
    );

endmodule

`default_nettype wire

//--- tb_host_ring_rx.sv
/*
 * Testbench for the host ring receive path.
 * Host memory model with random grants and out-of-order responses,
 * foreign responses on the shared channel, a throttled consumer,
 * and value checks against a trace of expected ring lines.
 */

`default_nettype none

`include "ring_config.svh"

module tb_host_ring_rx;

    timeunit 1ns;
    timeprecision 100ps;

    import host_chan_pkg::*;
    import ring_pkg::*;

    // One granted read that still waits for its response
    typedef struct packed {
        chan_tag_t  tag;
        line_addr_t addr;
    } pending_t;

    // One test phase as read from the trace
    typedef struct packed {
        ring_idx_t  newest;
        logic [7:0] grant_pct;
        logic       hold;
        logic [7:0] enable_pct;
    } phase_t;

    logic           clk = 1'b0;
    logic           reset_n;
    line_addr_t     ring_base;
    ring_idx_t      newest_idx;
    ring_idx_t      oldest_idx;
    host_read_req_t read_req;
    logic           read_grant;
    host_read_rsp_t read_rsp;
    line_data_t     rx_data;
    logic           rx_rdy;
    logic           rx_enable;

    // ====================
    // Trace contents
    // ====================

    line_addr_t trace_base;
    line_data_t mem_lines [16];
    line_data_t expected [$];
    phase_t     phases [$];

    // ====================
    // Run state
    // ====================

    pending_t pending [$];
    integer   seed = 70212;
    int       granted = 0;
    int       popped = 0;
    int       target = 0;
    int       grant_pct = 0;
    int       enable_pct = 0;
    logic     hold_active = 1'b0;
    logic     sb_limit_seen = 1'b0;
    int       mismatches = 0;
    int       other_errors = 0;
    int       cycle_count = 0;
    int       cycle_limit = 0;

    always #20 clk = ~clk;

    host_ring_rx dut
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .ring_base  (ring_base),
        .newest_idx (newest_idx),
        .oldest_idx (oldest_idx),
        .read_req   (read_req),
        .read_grant (read_grant),
        .read_rsp   (read_rsp),
        .rx_data    (rx_data),
        .rx_rdy     (rx_rdy),
        .rx_enable  (rx_enable)
    );

    // Uniform value in 0 .. n-1 from the seeded generator
    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'($unsigned(r) % n);
    endfunction

    task automatic note_error(input string msg);
        $display("Error at cycle %0d: %s", cycle_count, msg);
        other_errors++;
    endtask

    task automatic check_line(input string name, input line_data_t got, input line_data_t exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_addr(input string name, input line_addr_t got, input line_addr_t exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_idx(input string name, input ring_idx_t got, input ring_idx_t exp);
        if (got !== exp)
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    // ====================
    // Trace reader
    // ====================

    // Keyword records, a # token skips the rest of its line
    task automatic load_trace(output logic ok);
        int          fd;
        int          code;
        logic        done;
        logic [63:0] kw;
        logic [8*128-1:0] rest;
        logic [31:0] a, b, c, d, e;
        ring_idx_t   first_i;
        phase_t      ph;
        ok = 1'b1;
        fd = $fopen("ring_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Trace file ring_trace.txt could not be opened");
            ok = 1'b0;
        end
        else
        begin
            done = 1'b0;
            while (!done && !$feof(fd))
            begin
                code = $fscanf(fd, "%s", kw);
                if (code != 1)
                    done = 1'b1;
                else if (kw == 64'("#"))
                    code = $fgets(rest, fd);
                else if (kw == 64'("base"))
                begin
                    code = $fscanf(fd, "%h", a);
                    trace_base = line_addr_t'(a);
                end
                else if (kw == 64'("mem"))
                begin
                    // Four consecutive ring lines from the given index
                    code = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                    first_i = ring_idx_t'(a);
                    mem_lines[first_i] = b;
                    mem_lines[first_i + ring_idx_t'(1)] = c;
                    mem_lines[first_i + ring_idx_t'(2)] = d;
                    mem_lines[first_i + ring_idx_t'(3)] = e;
                end
                else if (kw == 64'("phase"))
                begin
                    code = $fscanf(fd, "%h %d %d %d", a, b, c, d);
                    ph.newest = ring_idx_t'(a);
                    ph.grant_pct = b[7:0];
                    ph.hold = c[0];
                    ph.enable_pct = d[7:0];
                    phases.push_back(ph);
                end
                else if (kw == 64'("expect"))
                begin
                    code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    expected.push_back(a);
                    expected.push_back(b);
                    expected.push_back(c);
                    expected.push_back(d);
                end
                else if (kw == 64'("end"))
                    done = 1'b1;
                else
                begin
                    $display("Unknown keyword in trace file");
                    ok = 1'b0;
                    done = 1'b1;
                end
            end
            $fclose(fd);
            if (expected.size() == 0 || phases.size() == 0)
            begin
                $display("Trace file holds no phases or no expected lines");
                ok = 1'b0;
            end
        end
    endtask

    // ====================
    // Per-cycle behavior
    // ====================

    task automatic idle_cycle();
        @(posedge clk);
        #5;
        read_grant = 1'b0;
        read_rsp = '0;
        rx_enable = 1'b0;
    endtask

    // Memory model, channel arbiter stand-in and consumer for one cycle
    task automatic run_cycle();
        int         pick;
        pending_t   ent;
        line_addr_t exp_addr;
        ring_idx_t  fifo_fill;
        @(posedge clk);
        #5;
        read_rsp = '0;
        read_grant = 1'b0;
        rx_enable = 1'b0;

        // Every outstanding read holds a scoreboard entry while responses are withheld
        if (pending.size() >= `SB_ENTRIES && read_req.request)
            note_error("Read request raised with all scoreboard entries outstanding");
        if (granted >= target && read_req.request)
            note_error("Read request raised past newest_idx");

        if (hold_active && (pending.size() == `SB_ENTRIES || granted == target))
        begin
            if (pending.size() == `SB_ENTRIES)
                sb_limit_seen = 1'b1;
            hold_active = 1'b0;
        end

        // Return one pending read in random order, or put foreign traffic on the channel
        if (!hold_active && pending.size() > 0 && rand_below(100) < 60)
        begin
            pick = rand_below(pending.size());
            ent = pending[pick];
            pending.delete(pick);
            read_rsp.valid = 1'b1;
            read_rsp.is_ring = 1'b1;
            read_rsp.tag = ent.tag;
            read_rsp.data = mem_lines[ring_idx_t'(ent.addr - ring_base)];
        end
        else if (rand_below(100) < 25)
        begin
            read_rsp.valid = 1'b1;
            read_rsp.is_ring = 1'b0;
            read_rsp.tag = chan_tag_t'(rand_below(`SB_ENTRIES));
            read_rsp.data = line_data_t'(32'hbad00000) | line_data_t'(rand_below(65536));
        end

        // Fewer than SB_ENTRIES lines granted and not yet popped leaves a scoreboard slot free
        // The request must then be raised, so the grant does not wait for it
        if (granted < target && (read_req.request || granted - popped < `SB_ENTRIES)
            && rand_below(100) < grant_pct)
        begin
            exp_addr = ring_base + line_addr_t'(ring_idx_t'(granted));
            check_addr("read_req.address", read_req.address, exp_addr);
            ent.tag = read_req.tag;
            ent.addr = read_req.address;
            pending.push_back(ent);
            granted++;
            read_grant = 1'b1;
        end

        // Lines between the release pointer and the consumer sit in the staging FIFO
        fifo_fill = oldest_idx - ring_idx_t'(popped);
        if (fifo_fill > ring_idx_t'(2))
            note_error($sformatf("oldest_idx %h is more than two lines past %0d popped lines",
                                 oldest_idx, popped));

        if (rx_rdy)
        begin
            if (popped >= expected.size())
                note_error("Consumer was offered a line beyond the expected count");
            else if (rand_below(100) < enable_pct)
            begin
                check_line("rx_data", rx_data, expected[popped]);
                popped++;
                rx_enable = 1'b1;
            end
        end
    endtask

    task automatic run_phase(input int idx);
        phase_t       ph;
        ring_idx_t    step;
        ring_status_t st;
        ph = phases[idx];
        idle_cycle();

        // Convert the wrapping newest_idx into an absolute line count
        step = ph.newest - newest_idx;
        target = target + int'(step);
        newest_idx = ph.newest;
        grant_pct = int'(ph.grant_pct);
        enable_pct = int'(ph.enable_pct);
        hold_active = ph.hold;
        sb_limit_seen = 1'b0;

        while (popped < target)
            run_cycle();

        // Let the output drain before looking at the pointers
        repeat (3) idle_cycle();
        check_idx("oldest_idx", oldest_idx, ring_idx_t'(popped));
        if (rx_rdy)
            note_error("A line is offered after all expected lines of the phase were taken");
        if (pending.size() != 0)
            note_error("Granted reads remain without a response at the end of the phase");
        if (ph.hold && !sb_limit_seen)
            note_error("Scoreboard never held all entries outstanding in the hold phase");

        st.oldest_idx = oldest_idx;
        st.newest_idx = newest_idx;
        $display("Phase %0d done: %0d lines, oldest %h newest %h",
                 idx, popped, st.oldest_idx, st.newest_idx);
    endtask

    // ====================
    // Checks outside the stimulus
    // ====================

    always @(negedge clk)
    begin
        if (reset_n && read_grant && !read_req.request)
            note_error("Grant issued in a cycle without a read request");
    end

    // Run limit, armed once the trace length is known
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
        begin
            $display("Timeout after %0d cycles with %0d of %0d lines received",
                     cycle_count, popped, expected.size());
            $display("Verification failed");
            $finish;
        end
    end

    initial
    begin
        logic trace_ok;
        int   ph_i;
        reset_n = 1'b0;
        ring_base = '0;
        newest_idx = '0;
        read_grant = 1'b0;
        read_rsp = '0;
        rx_enable = 1'b0;

        load_trace(trace_ok);
        if (!trace_ok)
            other_errors++;
        else
        begin
            cycle_limit = 60 * expected.size() + 200;
            ring_base = trace_base;
            repeat (2) @(posedge clk);
            #5;
            reset_n = 1'b1;
            for (ph_i = 0; ph_i < phases.size(); ph_i++)
                run_phase(ph_i);
            if (popped != expected.size())
                note_error("Phases ended before every expected line was received");
        end

        $display("Checks done: %0d value mismatches, %0d other errors",
                 mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- ring_trace.txt
# Records: base <line addr hex> | mem <first idx hex> <4 lines hex>
# phase <newest_idx hex> <grant pct dec> <hold 0/1> <rx_enable pct dec> | expect <4 lines hex>
base 0001235
# Sixteen ring lines in host memory
mem 0 3a1f0000 7b2e0011 c4d30022 05e40033
mem 4 96f50044 17a60055 e8b70066 29c80077
mem 8 5ad90088 ab0a0099 1c1b00aa 6d2c00bb
mem c fe3d00cc 0f4e00dd 705f00ee 81600ff0
# Short warm-up phase
phase 5 70 0 80
# Responses withheld until the scoreboard is full
phase e 100 1 90
# Wraps the ring with a slow consumer
phase 6 50 0 15
# Final lines after newest_idx advances again
phase 8 90 0 100
# Lines in ring order, wrapping after index f
expect 3a1f0000 7b2e0011 c4d30022 05e40033
expect 96f50044 17a60055 e8b70066 29c80077
expect 5ad90088 ab0a0099 1c1b00aa 6d2c00bb
expect fe3d00cc 0f4e00dd 705f00ee 81600ff0
expect 3a1f0000 7b2e0011 c4d30022 05e40033
expect 96f50044 17a60055 e8b70066 29c80077
end

//--- host_ring_rx.f
+incdir+.
host_chan_pkg.sv
ring_pkg.sv
stage_fifo2.sv
reorder_scoreboard.sv
ring_fifo_reader.sv
host_ring_rx.sv
tb_host_ring_rx.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --timing --timescale 1ns/100ps
TOP       := tb_host_ring_rx
FILELIST  := host_ring_rx.f
OBJDIR    := obj_dir
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary -j 0 $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The run passes only if the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
